/* hw/iob_fifo_pkg.sv */
package iob_fifo_pkg;

  // narrow write side, wide read side
  localparam int W_DATA_W = 8;
  localparam int R_DATA_W = 32;

  // bytes packed into one read word
  localparam int RATIO = R_DATA_W / W_DATA_W;

  // byte addressing sets the depth
  localparam int ADDR_W = 6;
  localparam int ADDR_W_DIFF = $clog2(RATIO);

  // the write side addresses bytes and the read side addresses words
  localparam int W_ADDR_W = ADDR_W;
  localparam int R_ADDR_W = ADDR_W - ADDR_W_DIFF;

  // capacity in bytes, one bit wider than the address so 64 fits
  localparam logic [ADDR_W:0] FIFO_SIZE = (ADDR_W + 1)'(1 << ADDR_W);

  // one storage entry is seen whole by the read port
  // and lane by lane by the write port
  typedef union packed {
    logic [R_DATA_W-1:0] word;
    logic [RATIO-1:0][W_DATA_W-1:0] lane;
  } mem_word_t;

endpackage

/* hw/iob_gray_counter.sv */
`timescale 1ns/1ns

module iob_gray_counter #(
  parameter int W = 4
) (
  input  logic         clk_i,
  input  logic         rst_i,
  input  logic         en_i,
  output logic [W-1:0] data_o
);

  // binary count kept next to the registered gray value
  logic [W-1:0] bin_q;
  logic [W-1:0] bin_next;

  assign bin_next = bin_q + 1'b1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      bin_q  <= '0;
      data_o <= '0;
    end else if (en_i) begin
      bin_q  <= bin_next;
      // gray encoding of the incremented count
      data_o <= bin_next ^ (bin_next >> 1);
    end
  end

  // the other domain samples this value, so every step
  // including the wrap has to flip a single bit
  gray_one_bit_step_a : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (data_o != $past(data_o)) |-> $onehot(data_o ^ $past(data_o))
  );

endmodule

/* hw/iob_sync.sv */
`timescale 1ns/1ns

module iob_sync #(
  parameter int DATA_W = 1
) (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic [DATA_W-1:0] signal_i,
  output logic [DATA_W-1:0] signal_o
);

  // first stage may go metastable, second stage settles it
  logic [DATA_W-1:0] sync_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync_q   <= '0;
      signal_o <= '0;
    end else begin
      sync_q   <= signal_i;
      signal_o <= sync_q;
    end
  end

  // only gray coded values cross here, at most one bit
  // differs between successive input samples

endmodule

/* hw/iob_ram_2p_asym.sv */
`timescale 1ns/1ns

module iob_ram_2p_asym (
  // byte write port
  input  logic                              w_clk_i,
  input  logic                              w_en_i,
  input  logic [iob_fifo_pkg::W_ADDR_W-1:0] w_addr_i,
  input  logic [iob_fifo_pkg::W_DATA_W-1:0] w_data_i,
  // word read port
  input  logic                              r_clk_i,
  input  logic                              r_en_i,
  input  logic [iob_fifo_pkg::R_ADDR_W-1:0] r_addr_i,
  output logic [iob_fifo_pkg::R_DATA_W-1:0] r_data_o
);

  import iob_fifo_pkg::*;

  // one entry per read word
  mem_word_t mem [2**R_ADDR_W];

  // write address split into entry and byte lane
  logic [R_ADDR_W-1:0]    w_entry;
  logic [ADDR_W_DIFF-1:0] w_lane;

  assign w_entry = w_addr_i[W_ADDR_W-1:ADDR_W_DIFF];
  assign w_lane  = w_addr_i[ADDR_W_DIFF-1:0];

  always_ff @(posedge w_clk_i) begin
    if (w_en_i) begin
      // lowest address lands in bits 7:0
      mem[w_entry].lane[w_lane] <= w_data_i;
    end
  end

  // registered read, output holds between reads
  always_ff @(posedge r_clk_i) begin
    if (r_en_i) begin
      r_data_o <= mem[r_addr_i].word;
    end
  end

endmodule

/* hw/iob_fifo_async.sv */
`timescale 1ns/1ns

module iob_fifo_async (
  input  logic                              w_clk_i,
  input  logic                              r_clk_i,
  input  logic                              rst_i,
  // write side
  input  logic                              w_en_i,
  input  logic [iob_fifo_pkg::W_DATA_W-1:0] w_data_i,
  output logic                              w_empty_o,
  output logic                              w_full_o,
  output logic [iob_fifo_pkg::ADDR_W:0]     w_level_o,
  // read side
  input  logic                              r_en_i,
  output logic                              r_empty_o,
  output logic                              r_full_o,
  output logic [iob_fifo_pkg::ADDR_W:0]     r_level_o,
  // memory write port
  output logic                              mem_w_en_o,
  output logic [iob_fifo_pkg::W_ADDR_W-1:0] mem_w_addr_o,
  output logic [iob_fifo_pkg::W_DATA_W-1:0] mem_w_data_o,
  // memory read port
  output logic                              mem_r_en_o,
  output logic [iob_fifo_pkg::R_ADDR_W-1:0] mem_r_addr_o
);

  import iob_fifo_pkg::*;

  // gray pointers, one extra bit tells full from empty
  logic [W_ADDR_W:0] w_waddr_gray;
  logic [W_ADDR_W:0] r_waddr_gray;
  logic [R_ADDR_W:0] r_raddr_gray;
  logic [R_ADDR_W:0] w_raddr_gray;

  // binary pointers in each domain
  logic [W_ADDR_W:0] w_waddr_bin;
  logic [W_ADDR_W:0] r_waddr_bin;
  logic [R_ADDR_W:0] r_raddr_bin;
  logic [R_ADDR_W:0] w_raddr_bin;

  // read pointers scaled to byte units
  logic [ADDR_W:0]   r_raddr_bin_n;
  logic [ADDR_W:0]   w_raddr_bin_n;

  // accepted accesses
  logic              w_en_int;
  logic              r_en_int;

  assign w_en_int = w_en_i & ~w_full_o;
  assign r_en_int = r_en_i & ~r_empty_o;

  // write pointer, one step per byte
  iob_gray_counter #(
    .W (W_ADDR_W + 1)
  ) w_waddr_gray_counter (
    .clk_i  (w_clk_i),
    .rst_i  (rst_i),
    .en_i   (w_en_int),
    .data_o (w_waddr_gray)
  );

  // read pointer, one step per word
  iob_gray_counter #(
    .W (R_ADDR_W + 1)
  ) r_raddr_gray_counter (
    .clk_i  (r_clk_i),
    .rst_i  (rst_i),
    .en_i   (r_en_int),
    .data_o (r_raddr_gray)
  );

  // write pointer into the read domain
  iob_sync #(
    .DATA_W (W_ADDR_W + 1)
  ) w_waddr_gray_sync (
    .clk_i    (r_clk_i),
    .rst_i    (rst_i),
    .signal_i (w_waddr_gray),
    .signal_o (r_waddr_gray)
  );

  // read pointer into the write domain
  iob_sync #(
    .DATA_W (R_ADDR_W + 1)
  ) r_raddr_gray_sync (
    .clk_i    (w_clk_i),
    .rst_i    (rst_i),
    .signal_i (r_raddr_gray),
    .signal_o (w_raddr_gray)
  );

  // gray to binary, bit i is the xor of all gray bits from i up
  always_comb begin
    for (int i = 0; i <= W_ADDR_W; i++) begin
      w_waddr_bin[i] = ^(w_waddr_gray >> i);
      r_waddr_bin[i] = ^(r_waddr_gray >> i);
    end
  end

  always_comb begin
    for (int i = 0; i <= R_ADDR_W; i++) begin
      r_raddr_bin[i] = ^(r_raddr_gray >> i);
      w_raddr_bin[i] = ^(w_raddr_gray >> i);
    end
  end

  // a word is RATIO bytes
  assign r_raddr_bin_n = {r_raddr_bin, {ADDR_W_DIFF{1'b0}}};
  assign w_raddr_bin_n = {w_raddr_bin, {ADDR_W_DIFF{1'b0}}};

  // read domain level and flags
  // empty once less than a whole word is stored
  assign r_level_o = r_waddr_bin - r_raddr_bin_n;
  assign r_empty_o = r_level_o < (ADDR_W + 1)'(RATIO);
  assign r_full_o  = r_level_o > (FIFO_SIZE - (ADDR_W + 1)'(RATIO));

  // write domain level and flags
  // full once there is no room for a single byte
  assign w_level_o = w_waddr_bin - w_raddr_bin_n;
  assign w_empty_o = w_level_o < (ADDR_W + 1)'(1);
  assign w_full_o  = w_level_o > (FIFO_SIZE - (ADDR_W + 1)'(1));

  // memory port
  assign mem_w_en_o   = w_en_int;
  assign mem_w_addr_o = w_waddr_bin[W_ADDR_W-1:0];
  assign mem_w_data_o = w_data_i;
  assign mem_r_en_o   = r_en_int;
  assign mem_r_addr_o = r_raddr_bin[R_ADDR_W-1:0];

  // an accepted write never pushes the stored count past the capacity,
  // even with a stale view of the read pointer
  w_no_overflow_a : assert property (
    @(posedge w_clk_i) disable iff (rst_i)
    mem_w_en_o |=> (w_level_o <= FIFO_SIZE)
  );

  // an accepted read never takes more than was stored, an underflow
  // would wrap the level to a value above the capacity
  r_no_underflow_a : assert property (
    @(posedge r_clk_i) disable iff (rst_i)
    mem_r_en_o |=> (r_level_o <= FIFO_SIZE)
  );

endmodule

/* hw/iob_fifo_async_sys.sv */
`timescale 1ns/1ns

module iob_fifo_async_sys (
  input  logic                              w_clk_i,
  input  logic                              r_clk_i,
  input  logic                              rst_i,
  // write side
  input  logic                              w_en_i,
  input  logic [iob_fifo_pkg::W_DATA_W-1:0] w_data_i,
  output logic                              w_full_o,
  output logic                              w_empty_o,
  output logic [iob_fifo_pkg::ADDR_W:0]     w_level_o,
  // read side
  input  logic                              r_en_i,
  output logic [iob_fifo_pkg::R_DATA_W-1:0] r_data_o,
  output logic                              r_empty_o,
  output logic                              r_full_o,
  output logic [iob_fifo_pkg::ADDR_W:0]     r_level_o
);

  import iob_fifo_pkg::*;

  // core to memory
  logic                mem_w_en;
  logic [W_ADDR_W-1:0] mem_w_addr;
  logic [W_DATA_W-1:0] mem_w_data;
  logic                mem_r_en;
  logic [R_ADDR_W-1:0] mem_r_addr;
  logic [R_DATA_W-1:0] mem_r_data;

  iob_fifo_async iob_fifo_async_inst (
    .w_clk_i      (w_clk_i),
    .r_clk_i      (r_clk_i),
    .rst_i        (rst_i),
    .w_en_i       (w_en_i),
    .w_data_i     (w_data_i),
    .w_empty_o    (w_empty_o),
    .w_full_o     (w_full_o),
    .w_level_o    (w_level_o),
    .r_en_i       (r_en_i),
    .r_empty_o    (r_empty_o),
    .r_full_o     (r_full_o),
    .r_level_o    (r_level_o),
    .mem_w_en_o   (mem_w_en),
    .mem_w_addr_o (mem_w_addr),
    .mem_w_data_o (mem_w_data),
    .mem_r_en_o   (mem_r_en),
    .mem_r_addr_o (mem_r_addr)
  );

  iob_ram_2p_asym iob_ram_2p_asym_inst (
    .w_clk_i  (w_clk_i),
    .w_en_i   (mem_w_en),
    .w_addr_i (mem_w_addr),
    .w_data_i (mem_w_data),
    .r_clk_i  (r_clk_i),
    .r_en_i   (mem_r_en),
    .r_addr_i (mem_r_addr),
    .r_data_o (mem_r_data)
  );

  // read data comes straight from the ram output register
  assign r_data_o = mem_r_data;

endmodule

/* verification/iob_fifo_async_tb.sv */
`timescale 1ns/1ns

module iob_fifo_async_tb;

  import iob_fifo_pkg::*;

  localparam int TIMEOUT_CYCLES = 100;
  localparam int STREAM_CYCLES  = 2000;

  logic                w_clk_i;
  logic                r_clk_i;
  logic                rst_i;
  logic                w_en_i;
  logic [W_DATA_W-1:0] w_data_i;
  logic                w_full_o;
  logic                w_empty_o;
  logic [ADDR_W:0]     w_level_o;
  logic                r_en_i;
  logic [R_DATA_W-1:0] r_data_o;
  logic                r_empty_o;
  logic                r_full_o;
  logic [ADDR_W:0]     r_level_o;

  // scoreboard of accepted bytes, oldest first
  logic [W_DATA_W-1:0] wr_q [$];

  string               test_name;
  string               check_name;
  logic                check_pending;
  logic [R_DATA_W-1:0] expected_word;
  logic                stream_done;

  iob_fifo_async_sys iob_fifo_async_sys_inst (
    .w_clk_i   (w_clk_i),
    .r_clk_i   (r_clk_i),
    .rst_i     (rst_i),
    .w_en_i    (w_en_i),
    .w_data_i  (w_data_i),
    .w_full_o  (w_full_o),
    .w_empty_o (w_empty_o),
    .w_level_o (w_level_o),
    .r_en_i    (r_en_i),
    .r_data_o  (r_data_o),
    .r_empty_o (r_empty_o),
    .r_full_o  (r_full_o),
    .r_level_o (r_level_o)
  );

  always #2 w_clk_i = ~w_clk_i;

  // read clock trails the write clock by 1 ns
  always begin
    #1;
    forever #2 r_clk_i = ~r_clk_i;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("[ERROR] %s: expected 0x%08h, actual 0x%08h", name, expected, actual));
    end
  endtask

  // first byte written lands in bits 7:0
  function automatic logic [R_DATA_W-1:0] pack_word();
    logic [R_DATA_W-1:0] word;
    word = '0;
    for (int i = 0; i < RATIO; i++) begin
      word[i*W_DATA_W +: W_DATA_W] = wr_q.pop_front();
    end
    return word;
  endfunction

  // write acceptance as seen at the edge
  always @(posedge w_clk_i) begin
    if (!rst_i && w_en_i && !w_full_o) begin
      wr_q.push_back(w_data_i);
    end
  end

  // compare the word one read cycle after its read was accepted
  always @(posedge r_clk_i) begin
    if (check_pending) begin
      check_equal(check_name, expected_word, r_data_o);
    end
    check_pending = 1'b0;
    if (!rst_i && r_en_i && !r_empty_o) begin
      if (wr_q.size() < RATIO) begin
        fail_run("a read was accepted before four bytes had been written");
      end
      expected_word = pack_word();
      check_name    = test_name;
      check_pending = 1'b1;
    end
  end

  task automatic await_empty(input logic value);
    int cycles;
    cycles = 0;
    while (r_empty_o !== value) begin
      @(posedge r_clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timed out waiting for r_empty_o");
    end
  endtask

  task automatic await_level(input logic [ADDR_W:0] value);
    int cycles;
    cycles = 0;
    while (r_level_o !== value) begin
      @(posedge r_clk_i);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timed out waiting for r_level_o");
    end
  endtask

  // hold w_en_i until n bytes are accepted
  task automatic write_bytes(input int n);
    int cycles;
    int count;
    cycles = 0;
    count  = 0;
    w_en_i   <= 1'b1;
    w_data_i <= W_DATA_W'($urandom);
    while (count < n) begin
      @(posedge w_clk_i);
      if (w_en_i && !w_full_o) begin
        count++;
        if (count == n) w_en_i <= 1'b0;
        else w_data_i <= W_DATA_W'($urandom);
      end
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timed out writing bytes");
    end
  endtask

  task automatic fill_until_full();
    int cycles;
    cycles = 0;
    w_en_i   <= 1'b1;
    w_data_i <= W_DATA_W'($urandom);
    while (1) begin
      @(posedge w_clk_i);
      if (w_full_o) break;
      w_data_i <= W_DATA_W'($urandom);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timed out waiting for w_full_o");
    end
  endtask

  task automatic read_words(input int n);
    int cycles;
    int count;
    cycles = 0;
    count  = 0;
    r_en_i <= 1'b1;
    while (count < n) begin
      @(posedge r_clk_i);
      if (r_en_i && !r_empty_o) begin
        count++;
        if (count == n) r_en_i <= 1'b0;
      end
      cycles++;
      if (cycles > TIMEOUT_CYCLES) fail_run("timed out reading words");
    end
  endtask

  // writes mostly enabled, reads rarely, so the FIFO reaches full
  task automatic stream_random();
    int cycles;
    cycles = 0;
    stream_done = 1'b0;
    fork
      begin
        for (int i = 0; i < STREAM_CYCLES; i++) begin
          @(posedge w_clk_i);
          w_en_i   <= ($urandom % 4) != 0;
          w_data_i <= W_DATA_W'($urandom);
        end
        @(posedge w_clk_i);
        w_en_i <= 1'b0;
        stream_done = 1'b1;
      end
      begin
        while (!stream_done) begin
          @(posedge r_clk_i);
          r_en_i <= ($urandom % 8) == 0;
          cycles++;
          if (cycles > STREAM_CYCLES + TIMEOUT_CYCLES) fail_run("random stream did not finish");
        end
      end
    join
  endtask

  // read until r_empty_o has stayed high past the sync latency
  task automatic drain_until_empty();
    int cycles;
    int quiet;
    cycles = 0;
    quiet  = 0;
    r_en_i <= 1'b1;
    while (quiet < 8) begin
      @(posedge r_clk_i);
      if (r_empty_o) quiet++;
      else quiet = 0;
      cycles++;
      if (cycles > 4 * TIMEOUT_CYCLES) fail_run("timed out draining the FIFO");
    end
    r_en_i <= 1'b0;
  endtask

  initial begin
    logic [R_DATA_W-1:0] held;
    w_clk_i       = 1'b0;
    r_clk_i       = 1'b0;
    rst_i         = 1'b1;
    w_en_i        = 1'b0;
    w_data_i      = '0;
    r_en_i        = 1'b0;
    check_pending = 1'b0;
    stream_done   = 1'b0;
    test_name     = "reset";
    check_name    = "reset";
    void'($urandom(32'h838de070));
    // the later read clock edge gives both domains five reset edges
    repeat (5) @(posedge r_clk_i);
    rst_i <= 1'b0;
    @(posedge w_clk_i);
    check_equal("reset w_empty", 1, w_empty_o);
    check_equal("reset w_full", 0, w_full_o);
    check_equal("reset w_level", 0, w_level_o);
    check_equal("reset r_empty", 1, r_empty_o);
    check_equal("reset r_full", 0, r_full_o);
    check_equal("reset r_level", 0, r_level_o);

    // fill, then keep writing while full
    fill_until_full();
    check_equal("fill w_level", 64, w_level_o);
    check_equal("fill w_empty", 0, w_empty_o);
    repeat (8) begin
      @(posedge w_clk_i);
      w_data_i <= W_DATA_W'($urandom);
    end
    w_en_i <= 1'b0;
    @(posedge w_clk_i);
    check_equal("fill byte count", 64, 32'(wr_q.size()));
    await_level(7'd64);
    check_equal("fill r_full", 1, r_full_o);

    test_name = "drain";
    read_words(16);
    await_empty(1'b1);
    @(posedge r_clk_i);
    held = r_data_o;
    r_en_i <= 1'b1;
    repeat (6) begin
      @(posedge r_clk_i);
      check_equal("read while empty", held, r_data_o);
    end
    r_en_i <= 1'b0;

    test_name = "partial word";
    write_bytes(3);
    await_level(7'd3);
    check_equal("three bytes r_empty", 1, r_empty_o);
    write_bytes(1);
    await_empty(1'b0);
    read_words(1);
    @(posedge r_clk_i);

    test_name = "random stream";
    stream_random();
    drain_until_empty();
    @(posedge r_clk_i);
    check_equal("leftover bytes", 32'(wr_q.size()), r_level_o);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* tb.f */
hw/iob_fifo_pkg.sv
hw/iob_gray_counter.sv
hw/iob_sync.sv
hw/iob_ram_2p_asym.sv
hw/iob_fifo_async.sv
hw/iob_fifo_async_sys.sv
verification/iob_fifo_async_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module iob_fifo_async_tb -f tb.f -Mdir obj_dir -o sim && \
./obj_dir/sim | tee /dev/stderr | grep -qF "Result: PASSED" && \
exit 0 || exit 1
